//--- pin_defs.svh
// Board pin subsystem parameters
// Pin count, reset counter width and input synchroniser depth

`ifndef PIN_DEFS_SVH
`define PIN_DEFS_SVH

// Pins handled by the crossbar and pad row
`define PIN_NUM 8

// Reset hold counter, full range is counted before release
`define RST_CNT_W 4

// Flops in each pad input synchroniser
`define SYNC_STAGES 2

`endif

//--- board_pkg.sv
// Board-level types
// Reset controller states and the peripheral drive bundle

`include "pin_defs.svh"

package board_pkg;

  // Reset controller FSM
  typedef enum logic [1:0] {
    RST_HOLD  = 2'd0,  // Waiting for lock and button release
    RST_COUNT = 2'd1,  // Counting out the hold time
    RST_RUN   = 2'd2   // System out of reset
  } rst_state_e;

  // Everything the peripherals want to put on pins
  typedef struct packed {
    logic [`PIN_NUM-1:0] gpio_out;
    logic [`PIN_NUM-1:0] gpio_en;
    logic                uart_tx;
    logic                spi_clk;
    logic                spi_copi;
  } periph_out_t;

endpackage : board_pkg

//--- pin_pkg.sv
// Pin crossbar types
// Drive source select, per-pin pad drive and configuration write strobe

`include "pin_defs.svh"

package pin_pkg;

  // Source that drives a pin
  typedef enum logic [2:0] {
    PIN_SEL_OFF      = 3'd0,
    PIN_SEL_GPIO     = 3'd1,
    PIN_SEL_UART_TX  = 3'd2,
    PIN_SEL_SPI_CLK  = 3'd3,
    PIN_SEL_SPI_COPI = 3'd4
  } pin_sel_e;

  // What the crossbar hands to one pad cell
  typedef struct packed {
    logic out;
    logic en;
  } pad_drive_t;

  // Single-cycle write into one pin's select register
  typedef struct packed {
    logic                        we;
    logic [$clog2(`PIN_NUM)-1:0] idx;
    pin_sel_e                    sel;
  } pin_cfg_wr_t;

endpackage : pin_pkg

//--- rst_ctrl.sv
// Board reset controller
// Holds the system in reset until PLL lock and button release, then counts

`timescale 1ns/1ns
`include "pin_defs.svh"

module rst_ctrl (
  input  logic clk_sys_i,
  input  logic arst_n_i,
  input  logic pll_locked_i,
  input  logic rst_btn_i,
  output logic sys_rst_n_o
);
  import board_pkg::*;

  rst_state_e            state_q, state_d;
  logic [`RST_CNT_W-1:0] cnt_q, cnt_d;
  logic                  rst_req;

  assign rst_req = ~pll_locked_i | rst_btn_i;  // Either condition holds reset

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      RST_HOLD: begin
        cnt_d = '0;
        if (!rst_req) begin
          state_d = RST_COUNT;
        end
      end
      RST_COUNT: begin
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == '1) begin  // Full range counted
          state_d = RST_RUN;
        end
      end
      RST_RUN: state_d = RST_RUN;
      default: state_d = RST_HOLD;
    endcase

    // Lost lock or button press restarts from hold
    if (rst_req) begin
      state_d = RST_HOLD;
      cnt_d   = '0;
    end
  end

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= RST_HOLD;
      cnt_q       <= '0;
      sys_rst_n_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      sys_rst_n_o <= (state_d == RST_RUN);  // Glitch-free release
    end
  end

endmodule : rst_ctrl

//--- pin_xbar.sv
// Pin crossbar
// Per-pin select registers and the drive source multiplexer

`timescale 1ns/1ns
`include "pin_defs.svh"

module pin_xbar (
  input  logic                                  clk_sys_i,
  input  logic                                  rst_n_i,
  input  pin_pkg::pin_cfg_wr_t                  cfg_wr_i,
  input  board_pkg::periph_out_t                periph_i,
  output pin_pkg::pad_drive_t [`PIN_NUM-1:0]    drive_o
);
  import pin_pkg::*;

  pin_sel_e sel_q [`PIN_NUM];

  // Select registers, one write strobe per cycle
  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `PIN_NUM; i++) begin
        sel_q[i] <= PIN_SEL_OFF;
      end
    end else if (cfg_wr_i.we) begin
      sel_q[cfg_wr_i.idx] <= cfg_wr_i.sel;
    end
  end

  // Drive mux
  always_comb begin
    for (int i = 0; i < `PIN_NUM; i++) begin
      case (sel_q[i])
        PIN_SEL_GPIO: begin
          drive_o[i].out = periph_i.gpio_out[i];
          drive_o[i].en  = periph_i.gpio_en[i];
        end
        PIN_SEL_UART_TX: begin
          drive_o[i].out = periph_i.uart_tx;
          drive_o[i].en  = 1'b1;
        end
        PIN_SEL_SPI_CLK: begin
          drive_o[i].out = periph_i.spi_clk;
          drive_o[i].en  = 1'b1;
        end
        PIN_SEL_SPI_COPI: begin
          drive_o[i].out = periph_i.spi_copi;
          drive_o[i].en  = 1'b1;
        end
        default: begin  // Off and unused codes leave the pin undriven
          drive_o[i].out = 1'b0;
          drive_o[i].en  = 1'b0;
        end
      endcase
    end
  end

endmodule : pin_xbar

//--- pad_cell.sv
// Single pin pad cell
// Registered output with enable gating, plus input synchroniser

`timescale 1ns/1ns
`include "pin_defs.svh"

module pad_cell (
  input  logic                clk_sys_i,
  input  logic                rst_n_i,
  input  pin_pkg::pad_drive_t drive_i,
  input  logic                pin_i,
  output logic                pin_o,
  output logic                pin_oe_o,
  output logic                pin_sync_o
);
  logic [`SYNC_STAGES-1:0] sync_q;

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pin_o    <= 1'b0;
      pin_oe_o <= 1'b0;
    end else begin
      pin_o    <= drive_i.out & drive_i.en;  // Pulled low when not enabled
      pin_oe_o <= drive_i.en;
    end
  end

  // Raw pin is asynchronous to the system clock
  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`SYNC_STAGES-2:0], pin_i};
    end
  end

  assign pin_sync_o = sync_q[`SYNC_STAGES-1];

endmodule : pad_cell

//--- pin_capture.sv
// Pin input capture
// Registered levels and sticky rising-edge flags with per-bit clear

`timescale 1ns/1ns
`include "pin_defs.svh"

module pin_capture (
  input  logic                clk_sys_i,
  input  logic                rst_n_i,
  input  logic [`PIN_NUM-1:0] pin_sync_i,
  input  logic [`PIN_NUM-1:0] edge_clr_i,
  output logic [`PIN_NUM-1:0] pin_level_o,
  output logic [`PIN_NUM-1:0] edge_o
);
  logic [`PIN_NUM-1:0] rise;
  logic [`PIN_NUM-1:0] edge_d;

  // Previous level is the registered one
  assign rise = pin_sync_i & ~pin_level_o;

  // Clear takes priority over a new edge
  assign edge_d = (edge_o | rise) & ~edge_clr_i;

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pin_level_o <= '0;
      edge_o      <= '0;
    end else begin
      pin_level_o <= pin_sync_i;
      edge_o      <= edge_d;  // Sets together with the level
    end
  end

endmodule : pin_capture

//--- board_top.sv
// Board pin subsystem top level
// Reset controller, pin crossbar, pad cell row and input capture

`timescale 1ns/1ns
`include "pin_defs.svh"

module board_top (
  input  logic                   clk_sys_i,
  input  logic                   arst_n_i,
  input  logic                   pll_locked_i,
  input  logic                   rst_btn_i,
  input  pin_pkg::pin_cfg_wr_t   cfg_wr_i,
  input  board_pkg::periph_out_t periph_i,
  input  logic [`PIN_NUM-1:0]    pin_i,
  input  logic [`PIN_NUM-1:0]    edge_clr_i,
  output logic [`PIN_NUM-1:0]    pin_o,
  output logic [`PIN_NUM-1:0]    pin_oe_o,
  output logic [`PIN_NUM-1:0]    pin_level_o,
  output logic [`PIN_NUM-1:0]    edge_o,
  output logic                   boot_ok_o
);
  import pin_pkg::*;

  logic                      sys_rst_n;  // Reset for everything past rst_ctrl
  pad_drive_t [`PIN_NUM-1:0] drive;
  logic [`PIN_NUM-1:0]       pin_sync;

  rst_ctrl u_rst_ctrl (
    .clk_sys_i   (clk_sys_i),
    .arst_n_i    (arst_n_i),
    .pll_locked_i(pll_locked_i),
    .rst_btn_i   (rst_btn_i),
    .sys_rst_n_o (sys_rst_n)
  );

  assign boot_ok_o = sys_rst_n;  // Boot-ok LED

  pin_xbar u_pin_xbar (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (sys_rst_n),
    .cfg_wr_i (cfg_wr_i),
    .periph_i (periph_i),
    .drive_o  (drive)
  );

  for (genvar i = 0; i < `PIN_NUM; i++) begin : g_pad
    pad_cell u_pad_cell (
      .clk_sys_i (clk_sys_i),
      .rst_n_i   (sys_rst_n),
      .drive_i   (drive[i]),
      .pin_i     (pin_i[i]),
      .pin_o     (pin_o[i]),
      .pin_oe_o  (pin_oe_o[i]),
      .pin_sync_o(pin_sync[i])
    );
  end

  pin_capture u_pin_capture (
    .clk_sys_i  (clk_sys_i),
    .rst_n_i    (sys_rst_n),
    .pin_sync_i (pin_sync),
    .edge_clr_i (edge_clr_i),
    .pin_level_o(pin_level_o),
    .edge_o     (edge_o)
  );

endmodule : board_top

//--- board_assert.sv
// Concurrent checks on the board pin subsystem
// Output gating in reset, enable gating and edge flag origin

`timescale 1ns/1ns
`include "pin_defs.svh"

module board_assert (
  input logic                clk_sys_i,
  input logic                arst_n_i,
  input logic                sys_rst_n_i,
  input logic [`PIN_NUM-1:0] pin_out_i,
  input logic [`PIN_NUM-1:0] pin_oe_i,
  input logic [`PIN_NUM-1:0] level_i,
  input logic [`PIN_NUM-1:0] edge_i
);

  // Pads stay undriven while the system is held in reset
  a_oe_in_reset: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
    !sys_rst_n_i |-> pin_oe_i == '0)
    else $error("Output enable high while system reset is asserted");

  a_out_gated: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
    (pin_out_i & ~pin_oe_i) == '0)
    else $error("Pin driven high without output enable");

  // A new flag needs a level rise on the same edge
  a_edge_with_level: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
    (edge_i & ~$past(edge_i) & ~(level_i & ~$past(level_i))) == '0)
    else $error("Edge flag set without a matching level rise");

endmodule : board_assert

bind board_top board_assert u_board_assert (
  .clk_sys_i  (clk_sys_i),
  .arst_n_i   (arst_n_i),
  .sys_rst_n_i(sys_rst_n),
  .pin_out_i  (pin_o),
  .pin_oe_i   (pin_oe_o),
  .level_i    (pin_level_o),
  .edge_i     (edge_o)
);

//--- tb_board_top.sv
// Testbench for the board pin subsystem
// Reset sequencing, table-driven crossbar checks and input edge capture

`timescale 1ns/1ns
`include "pin_defs.svh"

module tb_board_top;
  import board_pkg::*;
  import pin_pkg::*;

  typedef logic [$clog2(`PIN_NUM)-1:0] pin_idx_t;

  localparam int       BOOT_EDGES  = (1 << `RST_CNT_W) + 1;  // Entry edge plus the full count range
  localparam int       LEVEL_EDGES = `SYNC_STAGES + 1;
  localparam pin_idx_t EDGE_PIN    = 3'd5;

  logic                clk_sys;
  logic                arst_n;
  logic                pll_locked;
  logic                rst_btn;
  pin_cfg_wr_t         cfg_wr;
  periph_out_t         periph;
  logic [`PIN_NUM-1:0] pin_in;
  logic [`PIN_NUM-1:0] edge_clr;
  logic [`PIN_NUM-1:0] pin_out;
  logic [`PIN_NUM-1:0] pin_oe;
  logic [`PIN_NUM-1:0] pin_level;
  logic [`PIN_NUM-1:0] edge_flag;
  logic                boot_ok;

  // Stimulus table with one slot per entry in each queue
  string               name_q[$];
  pin_idx_t            idx_q[$];
  pin_sel_e            sel_q[$];
  periph_out_t         periph_q[$];
  logic [`PIN_NUM-1:0] pin_in_q[$];
  logic                exp_out_q[$];
  logic                exp_oe_q[$];
  logic [`PIN_NUM-1:0] exp_level_q[$];
  logic                table_ready = 1'b0;
  logic [31:0]         lcg_state;

  board_top dut0 (
    .clk_sys_i   (clk_sys),
    .arst_n_i    (arst_n),
    .pll_locked_i(pll_locked),
    .rst_btn_i   (rst_btn),
    .cfg_wr_i    (cfg_wr),
    .periph_i    (periph),
    .pin_i       (pin_in),
    .edge_clr_i  (edge_clr),
    .pin_o       (pin_out),
    .pin_oe_o    (pin_oe),
    .pin_level_o (pin_level),
    .edge_o      (edge_flag),
    .boot_ok_o   (boot_ok)
  );

  always #20 clk_sys = ~clk_sys;

  function automatic logic [31:0] lcg_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Pad result {pin_o, pin_oe_o} for a select value
  function automatic logic [1:0] expected_drive(pin_sel_e sel, periph_out_t p, pin_idx_t idx);
    case (sel)
      PIN_SEL_GPIO:     return {p.gpio_out[idx] & p.gpio_en[idx], p.gpio_en[idx]};
      PIN_SEL_UART_TX:  return {p.uart_tx, 1'b1};
      PIN_SEL_SPI_CLK:  return {p.spi_clk, 1'b1};
      PIN_SEL_SPI_COPI: return {p.spi_copi, 1'b1};
      default:          return 2'b00;
    endcase
  endfunction

  // Random peripheral outputs with the entry's own gpio bits forced
  task automatic add_entry(input string name, input pin_idx_t idx, input pin_sel_e sel,
                           input logic en_bit, input logic out_bit,
                           input logic [`PIN_NUM-1:0] pins);
    periph_out_t p;
    logic [31:0] r;
    logic [1:0]  drv;
    r = lcg_rand();
    p.gpio_out      = r[31 -: `PIN_NUM];
    p.gpio_en       = r[23 -: `PIN_NUM];
    p.uart_tx       = r[15];
    p.spi_clk       = r[14];
    p.spi_copi      = r[13];
    p.gpio_en[idx]  = en_bit;
    p.gpio_out[idx] = out_bit;
    drv = expected_drive(sel, p, idx);
    name_q.push_back(name);
    idx_q.push_back(idx);
    sel_q.push_back(sel);
    periph_q.push_back(p);
    pin_in_q.push_back(pins);
    exp_out_q.push_back(drv[1]);
    exp_oe_q.push_back(drv[0]);
    exp_level_q.push_back(pins);  // Level follows the pins once synchronised
  endtask

  task automatic build_table();
    add_entry("p0_gpio_on",       3'd0, PIN_SEL_GPIO,     1'b1, 1'b1, 8'h01);
    add_entry("p1_uart_tx",       3'd1, PIN_SEL_UART_TX,  1'b1, 1'b0, 8'h03);
    add_entry("p2_spi_clk",       3'd2, PIN_SEL_SPI_CLK,  1'b0, 1'b1, 8'h5a);
    add_entry("p3_spi_copi",      3'd3, PIN_SEL_SPI_COPI, 1'b1, 1'b1, 8'ha5);
    add_entry("p4_off",           3'd4, PIN_SEL_OFF,      1'b1, 1'b1, 8'hff);
    add_entry("p5_gpio_low",      3'd5, PIN_SEL_GPIO,     1'b1, 1'b0, 8'h00);
    add_entry("p6_gpio_en0_out1", 3'd6, PIN_SEL_GPIO,     1'b0, 1'b1, 8'h3c);
    add_entry("p6_gpio_en0_out0", 3'd6, PIN_SEL_GPIO,     1'b0, 1'b0, 8'hc3);
    add_entry("p7_uart_tx",       3'd7, PIN_SEL_UART_TX,  1'b0, 1'b0, 8'h80);
    add_entry("p1_back_off",      3'd1, PIN_SEL_OFF,      1'b1, 1'b1, 8'h7e);
    add_entry("p0_spi_copi",      3'd0, PIN_SEL_SPI_COPI, 1'b0, 1'b0, 8'h11);
    add_entry("p2_gpio_on",       3'd2, PIN_SEL_GPIO,     1'b1, 1'b1, 8'h24);
  endtask

  task automatic check_vec(input string name, input logic [`PIN_NUM-1:0] exp,
                           input logic [`PIN_NUM-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "Vector mismatch in %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s expected %b actual %b", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "Bit mismatch in %s", name);
    end
  endtask

  // Everything the system reset clears
  task automatic check_idle(input string name);
    check_bit(name, 1'b0, boot_ok);
    check_vec(name, '0, pin_out);
    check_vec(name, '0, pin_oe);
    check_vec(name, '0, pin_level);
    check_vec(name, '0, edge_flag);
  endtask

  // Called right after the edge that released lock or button
  task automatic check_boot(input string name);
    for (int k = 1; k <= BOOT_EDGES; k++) begin
      @(posedge clk_sys);
      @(negedge clk_sys);
      if (k < BOOT_EDGES) begin
        check_idle(name);
      end else begin
        check_bit(name, 1'b1, boot_ok);
      end
    end
  endtask

  task automatic apply_entry(input int n);
    @(posedge clk_sys);
    cfg_wr.we  <= 1'b1;
    cfg_wr.idx <= idx_q[n];
    cfg_wr.sel <= sel_q[n];
    periph     <= periph_q[n];
    pin_in     <= pin_in_q[n];
    @(posedge clk_sys);  // Write taken here
    cfg_wr.we  <= 1'b0;
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_bit(name_q[n], exp_out_q[n], pin_out[idx_q[n]]);
    check_bit(name_q[n], exp_oe_q[n], pin_oe[idx_q[n]]);
    repeat (LEVEL_EDGES - 1) @(posedge clk_sys);
    @(negedge clk_sys);
    check_vec(name_q[n], exp_level_q[n], pin_level);
  endtask

  task automatic apply_table();
    for (int n = 0; n < name_q.size(); n++) begin
      apply_entry(n);
    end
  endtask

  task automatic check_edge_capture();
    logic [`PIN_NUM-1:0] one_hot;
    logic [`PIN_NUM-1:0] exp;
    one_hot           = '0;
    one_hot[EDGE_PIN] = 1'b1;
    @(posedge clk_sys);
    pin_in   <= '0;
    edge_clr <= '1;
    repeat (LEVEL_EDGES + 1) @(posedge clk_sys);
    edge_clr <= '0;
    @(negedge clk_sys);
    check_vec("edge_start_level", '0, pin_level);
    check_vec("edge_start_flag", '0, edge_flag);
    @(posedge clk_sys);
    pin_in[EDGE_PIN] <= 1'b1;
    for (int k = 1; k <= LEVEL_EDGES; k++) begin
      @(posedge clk_sys);
      @(negedge clk_sys);
      exp = (k == LEVEL_EDGES) ? one_hot : '0;
      check_vec("edge_rise_level", exp, pin_level);
      check_vec("edge_rise_flag", exp, edge_flag);
    end
    @(posedge clk_sys);
    pin_in[EDGE_PIN] <= 1'b0;  // Flag must survive the fall
    repeat (LEVEL_EDGES + 1) @(posedge clk_sys);
    @(negedge clk_sys);
    check_vec("edge_fall_level", '0, pin_level);
    check_vec("edge_fall_flag", one_hot, edge_flag);
    @(posedge clk_sys);
    edge_clr <= one_hot;
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_vec("edge_cleared", '0, edge_flag);
    @(posedge clk_sys);
    edge_clr <= '0;
  endtask

  initial begin
    clk_sys    = 1'b0;
    arst_n     = 1'b0;
    pll_locked = 1'b0;
    rst_btn    = 1'b0;
    cfg_wr     = '0;
    periph     = '0;
    pin_in     = '0;
    edge_clr   = '0;
    lcg_state  = 32'd69;
    build_table();
    table_ready = 1'b1;

    repeat (4) @(posedge clk_sys);
    arst_n     <= 1'b1;
    pin_in     <= '1;  // Held capture must ignore these
    periph     <= '1;
    cfg_wr.we  <= 1'b1;  // Select writes blocked until release
    cfg_wr.sel <= PIN_SEL_UART_TX;
    repeat (3) @(posedge clk_sys);
    @(negedge clk_sys);
    check_idle("hold_unlocked");  // No lock yet
    @(posedge clk_sys);
    pll_locked <= 1'b1;
    cfg_wr.we  <= 1'b0;
    check_boot("boot");

    apply_table();
    check_edge_capture();

    @(posedge clk_sys);
    pll_locked <= 1'b0;
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_idle("pll_lost");
    @(posedge clk_sys);
    pll_locked <= 1'b1;
    check_boot("pll_relock");

    apply_table();

    @(posedge clk_sys);
    rst_btn <= 1'b1;
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_idle("button_pressed");
    @(posedge clk_sys);
    rst_btn <= 1'b0;
    check_boot("button_release");

    $display("Result: PASSED");
    $finish;
  end

  // Budget scales with the table
  initial begin
    wait (table_ready);
    repeat (name_q.size() * 10 + 200) @(posedge clk_sys);
    $display("Timeout: the tests did not finish within the cycle budget");
    $display("Result: FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule : tb_board_top

//--- list.f
+incdir+.
board_pkg.sv
pin_pkg.sv
rst_ctrl.sv
pin_xbar.sv
pad_cell.sv
pin_capture.sv
board_top.sv
board_assert.sv
tb_board_top.sv

//--- run.sh
#!/bin/sh
# Build and run the board pin subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_board_top \
  --Mdir "$BUILD_DIR" -o tb_board_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_board_top" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
